//--- common/sha3_pkg.sv
// SHA-3 algorithm package
// Widths, lane and state types, mode and strength enums,
// Keccak round constants and the rate lookup
`default_nettype none

package sha3_pkg;

  // Datapath widths
  parameter int StateW   = 1600;
  parameter int MsgWidth = 64;
  parameter int MsgStrbW = MsgWidth / 8;

  typedef logic [MsgWidth-1:0] lane_t;
  typedef logic [StateW-1:0]   state_t;
  typedef logic [4:0]          lane_idx_t;

  // Domain byte is 0x06 for SHA3 and 0x1F for SHAKE
  typedef enum logic {
    Sha3,
    Shake
  } sha3_mode_e;

  typedef enum logic [1:0] {
    L128,
    L256,
    L512
  } keccak_strength_e;

  parameter int NumRounds = 24;

  // Iota constants, one per round
  parameter lane_t RoundConst [NumRounds] = '{
    64'h0000_0000_0000_0001, 64'h0000_0000_0000_8082,
    64'h8000_0000_0000_808A, 64'h8000_0000_8000_8000,
    64'h0000_0000_0000_808B, 64'h0000_0000_8000_0001,
    64'h8000_0000_8000_8081, 64'h8000_0000_0000_8009,
    64'h0000_0000_0000_008A, 64'h0000_0000_0000_0088,
    64'h0000_0000_8000_8009, 64'h0000_0000_8000_000A,
    64'h0000_0000_8000_808B, 64'h8000_0000_0000_008B,
    64'h8000_0000_0000_8089, 64'h8000_0000_0000_8003,
    64'h8000_0000_0000_8002, 64'h8000_0000_0000_0080,
    64'h0000_0000_0000_800A, 64'h8000_0000_8000_000A,
    64'h8000_0000_8000_8081, 64'h8000_0000_0000_8080,
    64'h0000_0000_8000_0001, 64'h8000_0000_8000_8008
  };

  // Block size in lanes for each strength
  function automatic lane_idx_t rate_lanes(keccak_strength_e strength);
    lane_idx_t lanes;
    unique case (strength)
      L128:    lanes = 5'd21;
      L512:    lanes = 5'd9;
      default: lanes = 5'd17;
    endcase
    return lanes;
  endfunction

endpackage

`default_nettype wire

//--- common/sha3_ctrl_pkg.sv
// SHA-3 control package
// Core FSM states, error codes and error info type
`default_nettype none

package sha3_ctrl_pkg;

  // Main control FSM
  typedef enum logic [2:0] {
    StIdle,
    StAbsorb,
    StSqueeze,
    StManualRun,
    StFlush
  } sha3_st_e;

  typedef enum logic [7:0] {
    ErrNone          = 8'h00,
    ErrSha3SwControl = 8'h01
  } err_code_e;

  // Control snapshot at the time of the error
  //   [0] start
  //   [1] process
  //   [2] run
  //   [3] done
  typedef logic [3:0] err_info_t;

endpackage

`default_nettype wire

//--- common/keccak_lane_if.sv
// Lane channel between the padding unit and the Keccak engine
`timescale 1ns/1ns
`default_nettype none

interface keccak_lane_if
  import sha3_pkg::*;
();

  // Lane handshake
  logic  lane_valid;
  lane_t lane_data;
  logic  lane_ready;

  // Permutation start and end pulses
  logic  run;
  logic  complete;

  modport pad (output lane_valid, output lane_data, output run,
               input lane_ready, input complete);

  modport engine (input lane_valid, input lane_data, input run,
                  output lane_ready, output complete);

endinterface

`default_nettype wire

//--- keccak/keccak_round.sv
// Keccak-f[1600] permutation engine
// State register, lane absorb by XOR, round counter and round datapath
`timescale 1ns/1ns
`default_nettype none

module keccak_round
  import sha3_pkg::*;
#(
  parameter int RoundsPerClock = 1
) (
  input  logic          clk_i,
  input  logic          rst_b,
  keccak_lane_if.engine keccak,
  input  logic          squeezing_i,
  input  logic          clear_i,
  output state_t        state_o
);

  // Rho rotation per lane, index x + 5y
  localparam int RhoOff [25] = '{
     0,  1, 62, 28, 27,
    36, 44,  6, 55, 20,
     3, 10, 43, 25, 39,
    41, 45, 15, 21,  8,
    18,  2, 61, 56, 14
  };

  state_t     state_q;
  state_t     state_rnd;
  lane_idx_t  lane_cnt_q;
  logic [4:0] round_q;
  logic       busy_q;
  logic       last_step;
  logic       lane_xfer;

  function automatic lane_t rotl(lane_t v, int n);
    return (n == 0) ? v : ((v << n) | (v >> (MsgWidth - n)));
  endfunction

  // One full round on the state
  function automatic state_t keccak_rnd(state_t s, lane_t rc);
    lane_t  a [25];
    lane_t  b [25];
    lane_t  c [5];
    lane_t  d [5];
    state_t r;
    for (int i = 0; i < 25; i++) begin
      a[i] = s[MsgWidth*i +: MsgWidth];
    end
    // Theta column parity
    for (int x = 0; x < 5; x++) begin
      c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
    end
    for (int x = 0; x < 5; x++) begin
      d[x] = c[(x+4)%5] ^ rotl(c[(x+1)%5], 1);
    end
    for (int i = 0; i < 25; i++) begin
      a[i] = a[i] ^ d[i%5];
    end
    // Rho and pi, lane (x,y) moves to (y, 2x+3y)
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        b[y + 5*((2*x + 3*y) % 5)] = rotl(a[x + 5*y], RhoOff[x + 5*y]);
      end
    end
    // Chi along rows
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        r[MsgWidth*(x + 5*y) +: MsgWidth] =
          b[x + 5*y] ^ (~b[(x+1)%5 + 5*y] & b[(x+2)%5 + 5*y]);
      end
    end
    // Iota
    r[MsgWidth-1:0] = r[MsgWidth-1:0] ^ rc;
    return r;
  endfunction

  // Unrolled rounds for one cycle
  always_comb begin
    state_rnd = state_q;
    for (int i = 0; i < RoundsPerClock; i++) begin
      state_rnd = keccak_rnd(state_rnd, RoundConst[int'(round_q) + i]);
    end
  end

  assign last_step = busy_q && (round_q == 5'(NumRounds - RoundsPerClock));

  assign keccak.complete   = last_step;
  // No lanes while permuting or squeezing
  assign keccak.lane_ready = ~busy_q & ~squeezing_i;
  assign lane_xfer         = keccak.lane_valid & keccak.lane_ready;

  assign state_o = state_q;

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      state_q    <= '0;
      busy_q     <= 1'b0;
      round_q    <= '0;
      lane_cnt_q <= '0;
    end else if (clear_i) begin
      state_q    <= '0;
      busy_q     <= 1'b0;
      round_q    <= '0;
      lane_cnt_q <= '0;
    end else if (busy_q) begin
      state_q <= state_rnd;
      if (last_step) begin
        busy_q  <= 1'b0;
        round_q <= '0;
      end else begin
        round_q <= round_q + 5'(RoundsPerClock);
      end
    end else begin
      if (lane_xfer) begin
        state_q[MsgWidth*lane_cnt_q +: MsgWidth] <=
          state_q[MsgWidth*lane_cnt_q +: MsgWidth] ^ keccak.lane_data;
        lane_cnt_q <= lane_cnt_q + 5'd1;
      end
      // Lane count restarts with every permutation
      if (keccak.run) begin
        busy_q     <= 1'b1;
        round_q    <= '0;
        lane_cnt_q <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- sha3/sha3_pad.sv
// Message absorber and SHA3/SHAKE padding generator
// One lane per accepted beat, block runs and final padding block
`timescale 1ns/1ns
`default_nettype none

module sha3_pad
  import sha3_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_b,
  input  logic                msg_valid_i,
  input  lane_t               msg_data_i,
  input  logic [MsgStrbW-1:0] msg_strb_i,
  output logic                msg_ready_o,
  input  sha3_mode_e          mode_i,
  input  keccak_strength_e    strength_i,
  input  logic                start_i,
  input  logic                process_i,
  keccak_lane_if.pad          keccak,
  output logic                absorbed_o
);

  typedef enum logic [2:0] {
    PadIdle,
    PadMsg,
    PadFill,
    PadRun,
    PadWait
  } pad_st_e;

  pad_st_e          st_q, st_d;
  sha3_mode_e       mode_q;
  keccak_strength_e strength_q;
  lane_idx_t        cnt_q;
  lane_idx_t        rate;

  logic final_q;
  logic proc_q;
  logic part_q;
  logic dom_q;

  // Held partial word
  lane_t      part_data_q;
  logic [2:0] part_len_q;

  logic       last_lane;
  logic       full_strb;
  logic       lane_xfer;
  logic       part_capture;
  logic [2:0] strb_len;
  lane_t      strb_mask;
  lane_t      pad_lane;
  logic [7:0] dom_byte;

  assign rate      = rate_lanes(strength_q);
  assign last_lane = (cnt_q == lane_idx_t'(rate - 5'd1));
  assign full_strb = &msg_strb_i;
  assign dom_byte  = (mode_q == Shake) ? 8'h1F : 8'h06;
  assign lane_xfer = keccak.lane_valid & keccak.lane_ready;

  // Partial word is kept back until the padding starts
  assign part_capture = (st_q == PadMsg) & msg_valid_i & msg_ready_o & ~full_strb;

  // Byte count and byte mask of the strobe
  always_comb begin
    strb_len  = '0;
    strb_mask = '0;
    for (int i = 0; i < MsgStrbW; i++) begin
      if (msg_strb_i[i]) begin
        strb_len        = 3'(i + 1);
        strb_mask[8*i +: 8] = 8'hFF;
      end
    end
  end

  // Domain byte after the last message byte, 0x80 in the last rate byte
  always_comb begin
    pad_lane = '0;
    if (dom_q) begin
      if (part_q) begin
        pad_lane = part_data_q;
      end
      pad_lane = pad_lane | (lane_t'(dom_byte) << (8 * (part_q ? part_len_q : 3'd0)));
    end
    if (last_lane) begin
      pad_lane[MsgWidth-1] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pad FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    st_d              = st_q;
    msg_ready_o       = 1'b0;
    keccak.lane_valid = 1'b0;
    keccak.lane_data  = msg_data_i;
    keccak.run        = 1'b0;
    absorbed_o        = 1'b0;
    unique case (st_q)
      PadIdle: begin
        if (start_i) begin
          st_d = PadMsg;
        end
      end
      PadMsg: begin
        if (process_i || proc_q) begin
          st_d = PadFill;
        end else begin
          // Full beats go straight to the engine
          msg_ready_o       = keccak.lane_ready & ~part_q;
          keccak.lane_valid = msg_valid_i & full_strb & ~part_q;
          if (lane_xfer && last_lane) begin
            st_d = PadRun;
          end
        end
      end
      PadFill: begin
        keccak.lane_valid = 1'b1;
        keccak.lane_data  = pad_lane;
        if (lane_xfer && last_lane) begin
          st_d = PadRun;
        end
      end
      PadRun: begin
        keccak.run = 1'b1;
        st_d       = PadWait;
      end
      PadWait: begin
        if (keccak.complete) begin
          absorbed_o = final_q;
          st_d       = final_q ? PadIdle : PadMsg;
        end
      end
      default: begin
        st_d = PadIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      st_q       <= PadIdle;
      mode_q     <= Sha3;
      strength_q <= L256;
      cnt_q      <= '0;
      final_q    <= 1'b0;
      proc_q     <= 1'b0;
      part_q     <= 1'b0;
      dom_q      <= 1'b0;
    end else begin
      st_q <= st_d;
      // Latch the configuration for the whole message
      if (st_q == PadIdle && start_i) begin
        mode_q     <= mode_i;
        strength_q <= strength_i;
        cnt_q      <= '0;
        final_q    <= 1'b0;
        proc_q     <= 1'b0;
        part_q     <= 1'b0;
      end
      // Process may arrive while a block is still permuting
      if (process_i) begin
        proc_q <= 1'b1;
      end
      if (part_capture) begin
        part_q <= 1'b1;
      end
      if (st_q == PadMsg && st_d == PadFill) begin
        dom_q <= 1'b1;
      end
      if (lane_xfer) begin
        cnt_q <= last_lane ? '0 : cnt_q + 5'd1;
        if (st_q == PadFill) begin
          dom_q  <= 1'b0;
          part_q <= 1'b0;
        end
      end
      if (st_q == PadFill && st_d == PadRun) begin
        final_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (part_capture) begin
      part_data_q <= msg_data_i & strb_mask;
      part_len_q  <= strb_len;
    end
  end

endmodule

`default_nettype wire

//--- sha3/sha3_core.sv
// SHA-3 control core
// Control FSM, digest guard, manual run and software control errors
`timescale 1ns/1ns
`default_nettype none

module sha3_core
  import sha3_pkg::*;
  import sha3_ctrl_pkg::*;
#(
  parameter int RoundsPerClock = 1
) (
  input  logic                clk_i,
  input  logic                rst_b,
  input  logic                msg_valid_i,
  input  lane_t               msg_data_i,
  input  logic [MsgStrbW-1:0] msg_strb_i,
  output logic                msg_ready_o,
  input  sha3_mode_e          mode_i,
  input  keccak_strength_e    strength_i,
  input  logic                start_i,
  input  logic                process_i,
  input  logic                run_i,
  input  logic                done_i,
  output logic                absorbed_o,
  output logic                squeezing_o,
  output logic                block_processed_o,
  output sha3_st_e            sha3_fsm_o,
  output logic                state_valid_o,
  output state_t              state_o,
  output logic                error_valid_o,
  output err_code_e           error_code_o,
  output err_info_t           error_info_o
);

  sha3_st_e st_q, st_d;

  // Filtered controls towards pad and engine
  logic keccak_start;
  logic keccak_process;
  logic sw_run;

  // Second process_i while padding is an error
  logic processing_q;

  logic   pad_absorbed;
  logic   keccak_complete;
  logic   squeezing;
  logic   clear;
  logic   ctrl_err;
  state_t state;

  // Pad side and engine side of the lane channel
  keccak_lane_if u_pad_lane ();
  keccak_lane_if u_eng_lane ();

  ////////////////////////////////////////////////////////////
  // Lane channel join
  ////////////////////////////////////////////////////////////

  assign u_eng_lane.lane_valid = u_pad_lane.lane_valid;
  assign u_eng_lane.lane_data  = u_pad_lane.lane_data;
  // Engine runs on a block from the pad or on a manual run
  assign u_eng_lane.run        = u_pad_lane.run | sw_run;
  assign u_pad_lane.lane_ready = u_eng_lane.lane_ready;
  assign u_pad_lane.complete   = u_eng_lane.complete;

  assign keccak_complete   = u_eng_lane.complete;
  assign block_processed_o = keccak_complete;

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      st_q         <= StIdle;
      processing_q <= 1'b0;
      absorbed_o   <= 1'b0;
    end else begin
      st_q       <= st_d;
      absorbed_o <= pad_absorbed;
      if (keccak_process) begin
        processing_q <= 1'b1;
      end else if (pad_absorbed) begin
        processing_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    st_d           = st_q;
    keccak_start   = 1'b0;
    keccak_process = 1'b0;
    sw_run         = 1'b0;
    unique case (st_q)
      StIdle: begin
        if (start_i) begin
          st_d         = StAbsorb;
          keccak_start = 1'b1;
        end
      end
      StAbsorb: begin
        if (process_i && !processing_q) begin
          keccak_process = 1'b1;
        end else if (pad_absorbed) begin
          st_d = StSqueeze;
        end
      end
      StSqueeze: begin
        // Run wins over done
        if (run_i) begin
          st_d   = StManualRun;
          sw_run = 1'b1;
        end else if (done_i) begin
          st_d = StFlush;
        end
      end
      StManualRun: begin
        if (keccak_complete) begin
          st_d = StSqueeze;
        end
      end
      default: begin
        st_d = StIdle;
      end
    endcase
  end

  assign squeezing     = (st_q == StSqueeze) || (st_q == StManualRun);
  assign clear         = (st_q == StFlush);
  assign squeezing_o   = squeezing;
  assign sha3_fsm_o    = st_q;
  assign state_valid_o = (st_q == StSqueeze);

  // Digest guard, state only visible while squeezing idle
  assign state_o = (st_q == StSqueeze) ? state : '0;

  // Controls not allowed in the current state
  always_comb begin
    unique case (st_q)
      StIdle:    ctrl_err = process_i | run_i | done_i;
      StAbsorb:  ctrl_err = start_i | run_i | done_i | (process_i & processing_q);
      StSqueeze: ctrl_err = start_i | process_i;
      default:   ctrl_err = start_i | process_i | run_i | done_i;
    endcase
  end

  assign error_valid_o = ctrl_err;
  assign error_code_o  = ctrl_err ? ErrSha3SwControl : ErrNone;
  assign error_info_o  = ctrl_err ? {done_i, run_i, process_i, start_i} : '0;

  sha3_pad u_pad (
    .clk_i,
    .rst_b,
    .msg_valid_i,
    .msg_data_i,
    .msg_strb_i,
    .msg_ready_o,
    .mode_i,
    .strength_i,
    .start_i    (keccak_start),
    .process_i  (keccak_process),
    .keccak     (u_pad_lane.pad),
    .absorbed_o (pad_absorbed)
  );

  keccak_round #(
    .RoundsPerClock (RoundsPerClock)
  ) u_keccak (
    .clk_i,
    .rst_b,
    .keccak      (u_eng_lane.engine),
    .squeezing_i (squeezing),
    .clear_i     (clear),
    .state_o     (state)
  );

endmodule

`default_nettype wire

//--- source/sha3_top.sv
// SHA-3 subsystem top level
// Plain ports, sets the rounds per clock
`timescale 1ns/1ns
`default_nettype none

module sha3_top
  import sha3_pkg::*;
  import sha3_ctrl_pkg::*;
#(
  // One of 1, 2, 3, 4, 6, 8, 12 or 24
  parameter int RoundsPerClock = 2
) (
  input  logic                clk_i,
  input  logic                rst_b,
  // Message stream
  input  logic                msg_valid_i,
  input  lane_t               msg_data_i,
  input  logic [MsgStrbW-1:0] msg_strb_i,
  output logic                msg_ready_o,
  // Configuration
  input  sha3_mode_e          mode_i,
  input  keccak_strength_e    strength_i,
  // Software controls
  input  logic                start_i,
  input  logic                process_i,
  input  logic                run_i,
  input  logic                done_i,
  // Status and digest
  output logic                absorbed_o,
  output logic                squeezing_o,
  output logic                block_processed_o,
  output sha3_st_e            sha3_fsm_o,
  output logic                state_valid_o,
  output state_t              state_o,
  output logic                error_valid_o,
  output err_code_e           error_code_o,
  output err_info_t           error_info_o
);

  sha3_core #(
    .RoundsPerClock (RoundsPerClock)
  ) u_core (
    .clk_i,
    .rst_b,
    .msg_valid_i,
    .msg_data_i,
    .msg_strb_i,
    .msg_ready_o,
    .mode_i,
    .strength_i,
    .start_i,
    .process_i,
    .run_i,
    .done_i,
    .absorbed_o,
    .squeezing_o,
    .block_processed_o,
    .sha3_fsm_o,
    .state_valid_o,
    .state_o,
    .error_valid_o,
    .error_code_o,
    .error_info_o
  );

endmodule

`default_nettype wire

//--- bench/sha3_vectors.svh
// SHA-3 test vector table
// Message as a repeating byte pattern, mode, strength and digest prefix
`ifndef SHA3_VECTORS_SVH
`define SHA3_VECTORS_SVH

localparam int NumVec = 5;

// Columns: mode, strength, message length in bytes, pattern bytes
// (first byte in bits 7:0), pattern period in bytes, digest length
// in bytes, expected digest with its first byte in the top bits
typedef struct packed {
  sha3_mode_e       mode;
  keccak_strength_e strength;
  logic [15:0]      msg_len;
  logic [63:0]      pattern;
  logic [3:0]       pat_len;
  logic [7:0]       dig_len;
  logic [511:0]     digest;
} vec_t;

vec_t  vec_tbl  [NumVec];
string vec_name [NumVec];

task automatic load_vectors();
  vec_name[0] = "SHA3-256 empty";
  vec_tbl[0]  = '{Sha3, L256, 16'd0, 64'h0, 4'd1, 8'd32, {
    256'ha7ffc6f8_bf1ed766_51c14756_a061d662_f580ff4d_e43b49fa_82d80a4b_80f8434a,
    256'h0}};
  vec_name[1] = "SHA3-256 abc";
  vec_tbl[1]  = '{Sha3, L256, 16'd3, 64'h636261, 4'd3, 8'd32, {
    256'h3a985da7_4fe225b2_045c172d_6bd390bd_855f086e_3e9d525b_46bfe245_11431532,
    256'h0}};
  // Two blocks at the 136 byte rate
  vec_name[2] = "SHA3-256 200 x a3";
  vec_tbl[2]  = '{Sha3, L256, 16'd200, 64'ha3, 4'd1, 8'd32, {
    256'h79f38ade_c5c20307_a98ef76e_8324afbf_d46cfd81_b22e3973_c65fa1bd_9de31787,
    256'h0}};
  vec_name[3] = "SHA3-512 abc";
  vec_tbl[3]  = '{Sha3, L512, 16'd3, 64'h636261, 4'd3, 8'd64, {
    256'hb751850b_1a57168a_5693cd92_4b6b096e_08f62182_7444f70d_884f5d02_40d2712e,
    256'h10e116e9_192af3c9_1a7ec576_47e39340_57340b4c_f408d5a5_6592f827_4eec53f0}};
  // First 32 output bytes only
  vec_name[4] = "SHAKE128 empty";
  vec_tbl[4]  = '{Shake, L128, 16'd0, 64'h0, 4'd1, 8'd32, {
    256'h7f9c2ba4_e88f827d_61604550_7605853e_d73b8093_f6efbc88_eb1a6eac_fa66ef26,
    256'h0}};
endtask

`endif

//--- bench/sha3_tb.sv
// SHA-3 subsystem testbench
// Table-driven digests, back-pressure, digest guard, control errors,
// manual run and state clear
`timescale 1ns/1ns
`default_nettype none

module sha3_tb
  import sha3_pkg::*;
  import sha3_ctrl_pkg::*;
();

  localparam int RoundsPerClock = 2;
  // Cycle limit for each wait
  localparam int Timeout        = 400;

  logic                clk_i;
  logic                rst_b;
  logic                msg_valid_i;
  lane_t               msg_data_i;
  logic [MsgStrbW-1:0] msg_strb_i;
  logic                msg_ready_o;
  sha3_mode_e          mode_i;
  keccak_strength_e    strength_i;
  logic                start_i;
  logic                process_i;
  logic                run_i;
  logic                done_i;
  logic                absorbed_o;
  logic                squeezing_o;
  logic                block_processed_o;
  sha3_st_e            sha3_fsm_o;
  logic                state_valid_o;
  state_t              state_o;
  logic                error_valid_o;
  err_code_e           error_code_o;
  err_info_t           error_info_o;

  // Bookkeeping
  int          err_cnt;
  int          test_cnt;
  int          fail_cnt;
  int          test_err_base;
  string       test_name;
  int          blk_cnt;
  int          blk_base;

  `include "sha3_vectors.svh"

  sha3_top #(
    .RoundsPerClock (RoundsPerClock)
  ) dut0 (
    .clk_i,
    .rst_b,
    .msg_valid_i,
    .msg_data_i,
    .msg_strb_i,
    .msg_ready_o,
    .mode_i,
    .strength_i,
    .start_i,
    .process_i,
    .run_i,
    .done_i,
    .absorbed_o,
    .squeezing_o,
    .block_processed_o,
    .sha3_fsm_o,
    .state_valid_o,
    .state_o,
    .error_valid_o,
    .error_code_o,
    .error_info_o
  );

  // 100 ns clock
  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(string name, state_t got, state_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(string what);
    err_cnt++;
    $display("Timeout while waiting for %s at %0t ns", what, $time);
  endtask

  // Inputs change 10 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #10;
  endtask

  task automatic begin_test(string name);
    test_name     = name;
    test_err_base = err_cnt;
  endtask

  task automatic end_test();
    test_cnt++;
    if (err_cnt != test_err_base) begin
      fail_cnt++;
      $display("Test %0d %s: failed", test_cnt, test_name);
    end else begin
      $display("Test %0d %s: ok", test_cnt, test_name);
    end
  endtask

  // Block size in bytes per strength
  function automatic int block_bytes(keccak_strength_e s);
    int n;
    case (s)
      L128:    n = 168;
      L512:    n = 72;
      default: n = 136;
    endcase
    return n;
  endfunction

  function automatic logic [7:0] msg_byte(int v, int i);
    return vec_tbl[v].pattern[8*(i % int'(vec_tbl[v].pat_len)) +: 8];
  endfunction

  // Little-endian state bytes with the first byte on top as in the table
  function automatic logic [511:0] digest_of(int len);
    logic [511:0] d;
    d = '0;
    for (int i = 0; i < len; i++) begin
      d[511-8*i -: 8] = state_o[8*i +: 8];
    end
    return d;
  endfunction

  ////////////////////////////////////////////////////////////
  // Hash sequence
  ////////////////////////////////////////////////////////////

  task automatic start_hash(int v);
    blk_base   = blk_cnt;
    mode_i     = vec_tbl[v].mode;
    strength_i = vec_tbl[v].strength;
    start_i    = 1'b1;
    next_cycle();
    start_i = 1'b0;
  endtask

  task automatic feed_message(int v, bit with_gaps);
    int len;
    int nwords;
    int t;
    len    = int'(vec_tbl[v].msg_len);
    nwords = (len + 7) / 8;
    for (int w = 0; w < nwords; w++) begin
      // Idle cycles with msg_valid_i low
      if (with_gaps) begin
        repeat ($urandom % 4) next_cycle();
      end
      msg_valid_i = 1'b1;
      msg_data_i  = '0;
      msg_strb_i  = '0;
      for (int k = 0; k < MsgStrbW; k++) begin
        if (8*w + k < len) begin
          msg_data_i[8*k +: 8] = msg_byte(v, 8*w + k);
          msg_strb_i[k]        = 1'b1;
        end
      end
      // Beat transfers on the next edge once ready shows
      for (t = 0; t < Timeout; t++) begin
        @(negedge clk_i);
        if (msg_ready_o) begin
          break;
        end
        next_cycle();
      end
      if (t == Timeout) begin
        report_timeout("msg_ready_o");
      end
      next_cycle();
      msg_valid_i = 1'b0;
    end
  endtask

  // Returns in the middle of the absorbed_o cycle
  task automatic process_and_wait();
    int t;
    process_i = 1'b1;
    next_cycle();
    process_i = 1'b0;
    for (t = 0; t < Timeout; t++) begin
      @(negedge clk_i);
      if (absorbed_o) begin
        break;
      end
      next_cycle();
    end
    if (t == Timeout) begin
      report_timeout("absorbed_o");
    end
  endtask

  task automatic check_digest(int v);
    check_value("squeezing_o", state_t'(squeezing_o), state_t'(1));
    check_value("state_valid_o", state_t'(state_valid_o), state_t'(1));
    check_value("sha3_fsm_o", state_t'(sha3_fsm_o), state_t'(StSqueeze));
    check_value("state_o", state_t'(digest_of(int'(vec_tbl[v].dig_len))),
                state_t'(vec_tbl[v].digest));
  endtask

  // Data blocks plus the padding block
  task automatic check_blocks(int v);
    int exp;
    exp = int'(vec_tbl[v].msg_len) / block_bytes(vec_tbl[v].strength) + 1;
    check_value("block_processed_o pulses", state_t'(blk_cnt - blk_base), state_t'(exp));
  endtask

  // Done, then one flush cycle, then idle
  task automatic finish_hash();
    next_cycle();
    done_i = 1'b1;
    next_cycle();
    done_i = 1'b0;
    @(negedge clk_i);
    check_value("sha3_fsm_o", state_t'(sha3_fsm_o), state_t'(StFlush));
    next_cycle();
    @(negedge clk_i);
    check_value("sha3_fsm_o", state_t'(sha3_fsm_o), state_t'(StIdle));
    next_cycle();
  endtask

  task automatic run_vector(int v, bit with_gaps);
    start_hash(v);
    feed_message(v, with_gaps);
    process_and_wait();
    check_digest(v);
    check_blocks(v);
    finish_hash();
  endtask

  task automatic check_error(err_info_t info);
    check_value("error_valid_o", state_t'(error_valid_o), state_t'(1));
    check_value("error_code_o", state_t'(error_code_o), state_t'(ErrSha3SwControl));
    check_value("error_info_o", state_t'(error_info_o), state_t'(info));
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic control_error_test();
    // Process in idle
    process_i = 1'b1;
    @(negedge clk_i);
    check_error(4'b0010);
    next_cycle();
    process_i = 1'b0;
    @(negedge clk_i);
    check_value("sha3_fsm_o", state_t'(sha3_fsm_o), state_t'(StIdle));
    check_value("error_valid_o", state_t'(error_valid_o), state_t'(0));
    next_cycle();
    // Start while squeezing
    start_hash(1);
    feed_message(1, 1'b0);
    process_and_wait();
    check_digest(1);
    next_cycle();
    start_i = 1'b1;
    @(negedge clk_i);
    check_error(4'b0001);
    next_cycle();
    start_i = 1'b0;
    @(negedge clk_i);
    check_value("error_valid_o", state_t'(error_valid_o), state_t'(0));
    check_digest(1);
    finish_hash();
    // Next hash still good
    run_vector(0, 1'b0);
  endtask

  task automatic manual_run_test();
    state_t first;
    int     n;
    int     t;
    start_hash(4);
    feed_message(4, 1'b0);
    process_and_wait();
    check_digest(4);
    first = state_o;
    next_cycle();
    run_i = 1'b1;
    n     = 0;
    for (t = 0; t < Timeout; t++) begin
      next_cycle();
      n++;
      if (n == 1) begin
        run_i = 1'b0;
      end
      @(negedge clk_i);
      if (n == 1) begin
        check_value("state_valid_o", state_t'(state_valid_o), state_t'(0));
      end
      if (state_valid_o) begin
        break;
      end
    end
    if (t == Timeout) begin
      report_timeout("state_valid_o after run_i");
    end
    check_value("manual run cycles", state_t'(n), state_t'(24 / RoundsPerClock + 1));
    check_value("state_o nonzero", state_t'(|state_o), state_t'(1));
    check_value("state_o changed", state_t'(state_o != first), state_t'(1));
    finish_hash();
  endtask

  // Guard and FSM watch on every cycle plus completion count
  always @(negedge clk_i) begin
    if (rst_b) begin
      if (block_processed_o) begin
        blk_cnt++;
      end
      if (!state_valid_o) begin
        check_value("state_o", state_o, '0);
      end else begin
        check_value("sha3_fsm_o", state_t'(sha3_fsm_o), state_t'(StSqueeze));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h49fe8f2d));
    err_cnt     = 0;
    test_cnt    = 0;
    fail_cnt    = 0;
    blk_cnt     = 0;
    blk_base    = 0;
    rst_b       = 1'b0;
    msg_valid_i = 1'b0;
    msg_data_i  = '0;
    msg_strb_i  = '0;
    mode_i      = Sha3;
    strength_i  = L256;
    start_i     = 1'b0;
    process_i   = 1'b0;
    run_i       = 1'b0;
    done_i      = 1'b0;
    load_vectors();
    repeat (5) @(posedge clk_i);
    #10;
    rst_b = 1'b1;

    begin_test("reset state");
    @(negedge clk_i);
    check_value("msg_ready_o", state_t'(msg_ready_o), '0);
    check_value("absorbed_o", state_t'(absorbed_o), '0);
    check_value("squeezing_o", state_t'(squeezing_o), '0);
    check_value("state_valid_o", state_t'(state_valid_o), '0);
    check_value("block_processed_o", state_t'(block_processed_o), '0);
    check_value("error_valid_o", state_t'(error_valid_o), '0);
    check_value("state_o", state_o, '0);
    check_value("sha3_fsm_o", state_t'(sha3_fsm_o), state_t'(StIdle));
    end_test();
    next_cycle();

    for (int v = 0; v < NumVec; v++) begin
      begin_test(vec_name[v]);
      run_vector(v, 1'b0);
      end_test();
    end

    begin_test("back-pressure 200 x a3");
    run_vector(2, 1'b1);
    end_test();

    begin_test("control errors");
    control_error_test();
    end_test();

    begin_test("manual run");
    manual_run_test();
    end_test();

    // Same digest after the flush
    begin_test("clear then repeat abc");
    run_vector(1, 1'b0);
    end_test();

    $display("Tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sha3.f
+incdir+bench
common/sha3_pkg.sv
common/sha3_ctrl_pkg.sv
common/keccak_lane_if.sv
keccak/keccak_round.sv
sha3/sha3_pad.sv
sha3/sha3_core.sv
source/sha3_top.sv
bench/sha3_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SHA-3 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module sha3_tb -f sha3.f -o sha3_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sha3_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qF -- '** PASS **'; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
